// File: build.f
hdl/riscvPkg.sv
hdl/memMapPkg.sv
hdl/timerBusIf.sv
hdl/excDetect.sv
hdl/trapCsr.sv
hdl/mtimer.sv
hdl/busArbiter.sv
hdl/trapUnitTop.sv
sim/trapUnitTb.sv

// File: hdl/busArbiter.sv
`timescale 1ns/1ns

module busArbiter (
    input  logic        clk_i,
    input  logic        rstN_i,
    timerBusIf.arbiter  core,
    timerBusIf.arbiter  host,
    timerBusIf.master   slave
);

    typedef enum logic {
        OWN_CORE = 1'b0,
        OWN_HOST = 1'b1
    } owner_t;

    owner_t lastOwner;
    owner_t sel;

    // Core first, idle bus stays parked on the last owner
    always_comb begin
        if (core.req) begin
            sel = OWN_CORE;
        end else if (host.req) begin
            sel = OWN_HOST;
        end else begin
            sel = lastOwner;
        end
    end

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            lastOwner <= OWN_CORE;
        end else begin
            lastOwner <= sel;
        end
    end

    assign slave.req   = core.req || host.req;
    assign slave.we    = (sel == OWN_HOST) ? host.we    : core.we;
    assign slave.addr  = (sel == OWN_HOST) ? host.addr  : core.addr;
    assign slave.wdata = (sel == OWN_HOST) ? host.wdata : core.wdata;

    assign core.grant = core.req && slave.grant;
    assign host.grant = host.req && !core.req && slave.grant;

    assign core.rdata = (sel == OWN_CORE) ? slave.rdata : '0;
    assign host.rdata = (sel == OWN_HOST) ? slave.rdata : '0;

endmodule

// File: hdl/excDetect.sv
`timescale 1ns/1ns

module excDetect #(
    parameter int ramAddrWidth = 16
) (
    input  logic                   instValid_i,
    input  logic                   shouldJump_i,
    input  logic [31:0]            pcJumpDst_i,
    input  logic [31:0]            pc_i,
    input  logic [31:0]            dataAddress_i,
    input  riscvPkg::memInstType_t memInstType_i,
    input  logic                   instInvalid_i,
    input  logic                   priv_i,
    input  logic [31:0]            privCause_i,
    input  logic [31:0]            storeData_i,
    input  logic                   mtimeExc_i,
    output logic [31:0]            excCause_o,
    output logic [31:0]            trapInfo_o,
    output logic                   excPresent_o,
    output logic [31:0]            loadData_o,
    timerBusIf.master              bus
);

    logic        pcInRam;
    logic        dataInRam;
    logic        dataInTimer;
    logic        isLoad;
    logic        isStore;
    logic        halfAccess;
    logic        wordAccess;
    logic        misaligned;
    logic        timerAccess;
    logic        excPresent;
    logic [31:0] excCause;
    logic [31:0] trapInfo;

    assign pcInRam     = pc_i[31:ramAddrWidth] == memMapPkg::RAM_BASE[31:ramAddrWidth];
    assign dataInRam   = dataAddress_i[31:ramAddrWidth] == memMapPkg::RAM_BASE[31:ramAddrWidth];
    assign dataInTimer = (dataAddress_i >= memMapPkg::TIMER_LOW)
                      && (dataAddress_i <= memMapPkg::TIMER_HIGH);

    // Access direction and size
    always_comb begin
        isLoad     = 1'b0;
        isStore    = 1'b0;
        halfAccess = 1'b0;
        wordAccess = 1'b0;
        case (memInstType_i)
            riscvPkg::MEM_LB, riscvPkg::MEM_LBU: begin
                isLoad = 1'b1;
            end
            riscvPkg::MEM_LH, riscvPkg::MEM_LHU: begin
                isLoad     = 1'b1;
                halfAccess = 1'b1;
            end
            riscvPkg::MEM_LW: begin
                isLoad     = 1'b1;
                wordAccess = 1'b1;
            end
            riscvPkg::MEM_SB: begin
                isStore = 1'b1;
            end
            riscvPkg::MEM_SH: begin
                isStore    = 1'b1;
                halfAccess = 1'b1;
            end
            riscvPkg::MEM_SW: begin
                isStore    = 1'b1;
                wordAccess = 1'b1;
            end
            default: begin
            end
        endcase
    end

    assign misaligned = (halfAccess && dataAddress_i[0])
                     || (wordAccess && (dataAddress_i[1:0] != 2'b00));

    // Priority chain, first match wins
    always_comb begin
        excPresent  = 1'b0;
        excCause    = '0;
        trapInfo    = '0;
        timerAccess = 1'b0;
        if (instValid_i) begin
            if (shouldJump_i && (pcJumpDst_i[1:0] != 2'b00)) begin
                excPresent = 1'b1;
                excCause   = riscvPkg::M_INSTR_MISALIGN;
                trapInfo   = pcJumpDst_i;
            end else if (!pcInRam) begin
                excPresent = 1'b1;
                excCause   = riscvPkg::M_INSTR_AFAULT;
                trapInfo   = pc_i;
            end else if (instInvalid_i) begin
                excPresent = 1'b1;
                excCause   = riscvPkg::M_ILL_INSTR;
                trapInfo   = pc_i;
            end else if (priv_i) begin
                excPresent = 1'b1;
                excCause   = privCause_i;
                trapInfo   = pc_i;
            end else if (isLoad || isStore) begin
                if (!dataInRam && !dataInTimer) begin
                    excPresent = 1'b1;
                    excCause   = isStore ? riscvPkg::M_STORE_AFAULT : riscvPkg::M_LOAD_AFAULT;
                    trapInfo   = dataAddress_i;
                end else if (misaligned) begin
                    excPresent = 1'b1;
                    excCause   = isStore ? riscvPkg::M_STORE_MISALIGN
                                         : riscvPkg::M_LOAD_MISALIGN;
                    trapInfo   = dataAddress_i;
                end else begin
                    timerAccess = dataInTimer;
                end
            end else if (mtimeExc_i) begin
                excPresent = 1'b1;
                excCause   = riscvPkg::M_TIMER_INT;
            end
        end
    end

    assign excPresent_o = excPresent;
    assign excCause_o   = excCause;
    assign trapInfo_o   = trapInfo;

    // Core side of the timer bus
    assign bus.req   = timerAccess;
    assign bus.we    = isStore;
    assign bus.addr  = dataAddress_i;
    assign bus.wdata = storeData_i;

    assign loadData_o = (bus.grant && isLoad) ? bus.rdata : '0;

endmodule

// File: hdl/memMapPkg.sv
package memMapPkg;

    localparam logic [31:0] RAM_BASE    = 32'h8000_0000;

    // Machine timer registers, one word each
    localparam logic [31:0] MTIME_LO    = 32'hFFFF_0000;
    localparam logic [31:0] MTIME_HI    = 32'hFFFF_0004;
    localparam logic [31:0] MTIMECMP_LO = 32'hFFFF_0008;
    localparam logic [31:0] MTIMECMP_HI = 32'hFFFF_000C;

    // Inclusive bounds of the timer window
    localparam logic [31:0] TIMER_LOW   = MTIME_LO;
    localparam logic [31:0] TIMER_HIGH  = MTIMECMP_HI + 32'd3;

endpackage

// File: hdl/mtimer.sv
`timescale 1ns/1ns

module mtimer (
    input  logic      clk_i,
    input  logic      rstN_i,
    output logic      timerPending_o,
    timerBusIf.slave  bus
);

    logic [63:0] mtime;
    logic [63:0] mtimecmp;
    logic [63:0] mtimeNext;
    logic [31:0] wordAddr;
    logic        wrEn;

    assign wordAddr  = {bus.addr[31:2], 2'b00};
    assign wrEn      = bus.req && bus.we;
    assign mtimeNext = mtime + 64'd1;

    // Always ready, access completes in the request cycle
    assign bus.grant = bus.req;

    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            mtime    <= '0;
            mtimecmp <= '1;
        end else begin
            mtime <= mtimeNext;
            if (wrEn) begin
                case (wordAddr)
                    memMapPkg::MTIME_LO:    mtime          <= {mtimeNext[63:32], bus.wdata};
                    memMapPkg::MTIME_HI:    mtime          <= {bus.wdata, mtimeNext[31:0]};
                    memMapPkg::MTIMECMP_LO: mtimecmp[31:0]  <= bus.wdata;
                    memMapPkg::MTIMECMP_HI: mtimecmp[63:32] <= bus.wdata;
                    default: begin
                    end
                endcase
            end
        end
    end

    // Read mux
    always_comb begin
        case (wordAddr)
            memMapPkg::MTIME_LO:    bus.rdata = mtime[31:0];
            memMapPkg::MTIME_HI:    bus.rdata = mtime[63:32];
            memMapPkg::MTIMECMP_LO: bus.rdata = mtimecmp[31:0];
            memMapPkg::MTIMECMP_HI: bus.rdata = mtimecmp[63:32];
            default:                bus.rdata = '0;
        endcase
    end

    assign timerPending_o = mtime >= mtimecmp;

endmodule

// File: hdl/riscvPkg.sv
package riscvPkg;

    // Memory instruction kinds, as decoded by the core
    typedef enum logic [3:0] {
        MEM_NONE = 4'd0,
        MEM_LB   = 4'd1,
        MEM_LH   = 4'd2,
        MEM_LW   = 4'd3,
        MEM_LBU  = 4'd4,
        MEM_LHU  = 4'd5,
        MEM_SB   = 4'd6,
        MEM_SH   = 4'd7,
        MEM_SW   = 4'd8
    } memInstType_t;

    // Synchronous exception causes
    localparam logic [31:0] M_INSTR_MISALIGN = 32'd0;
    localparam logic [31:0] M_INSTR_AFAULT   = 32'd1;
    localparam logic [31:0] M_ILL_INSTR      = 32'd2;
    localparam logic [31:0] M_LOAD_MISALIGN  = 32'd4;
    localparam logic [31:0] M_LOAD_AFAULT    = 32'd5;
    localparam logic [31:0] M_STORE_MISALIGN = 32'd6;
    localparam logic [31:0] M_STORE_AFAULT   = 32'd7;

    // Interrupt bit set in the MSB
    localparam logic [31:0] M_TIMER_INT      = 32'h8000_0007;

endpackage

// File: hdl/timerBusIf.sv
`timescale 1ns/1ns

interface timerBusIf;
    logic        req;
    logic        we;
    logic [31:0] addr;
    logic [31:0] wdata;
    logic [31:0] rdata;
    logic        grant;

    modport master (
        output req, we, addr, wdata,
        input  rdata, grant
    );

    modport slave (
        input  req, we, addr, wdata,
        output rdata, grant
    );

    // Arbiter faces a master, so it answers like a slave
    modport arbiter (
        input  req, we, addr, wdata,
        output rdata, grant
    );
endinterface

// File: hdl/trapCsr.sv
`timescale 1ns/1ns

module trapCsr #(
    parameter logic [31:0] mtvecAddr = 32'h8000_0100
) (
    input  logic        clk_i,
    input  logic        rstN_i,
    input  logic        trapIn_i,
    input  logic [31:0] excCause_i,
    input  logic [31:0] trapInfo_i,
    input  logic [31:0] pc_i,
    input  logic        mret_i,
    input  logic        irqEnable_i,
    input  logic        timerPending_i,
    output logic        mtimeExc_o,
    output logic [31:0] mcause_o,
    output logic [31:0] mepc_o,
    output logic [31:0] mtval_o,
    output logic        trapTaken_o,
    output logic [31:0] trapTarget_o
);

    logic        mie;
    logic        mpie;
    logic        trapTaken;
    logic [31:0] mcause;
    logic [31:0] mepc;
    logic [31:0] mtval;

    // Interrupt enable stack
    always_ff @(posedge clk_i) begin
        if (!rstN_i) begin
            mie       <= 1'b0;
            mpie      <= 1'b0;
            trapTaken <= 1'b0;
        end else begin
            trapTaken <= trapIn_i;
            if (trapIn_i) begin
                mpie <= mie;
                mie  <= 1'b0;
            end else if (mret_i) begin
                mie  <= mpie;
                mpie <= 1'b1;
            end else if (irqEnable_i) begin
                mie <= 1'b1;
            end
        end
    end

    // Trap state capture
    always_ff @(posedge clk_i) begin
        if (trapIn_i) begin
            mcause <= excCause_i;
            mepc   <= pc_i;
            mtval  <= trapInfo_i;
        end
    end

    // Pending timer only counts while interrupts are on
    assign mtimeExc_o = timerPending_i && mie;

    assign mcause_o     = mcause;
    assign mepc_o       = mepc;
    assign mtval_o      = mtval;
    assign trapTaken_o  = trapTaken;
    assign trapTarget_o = mtvecAddr;

endmodule

// File: hdl/trapUnitTop.sv
`timescale 1ns/1ns

module trapUnitTop #(
    parameter int          ramAddrWidth = 16,
    parameter logic [31:0] mtvecAddr    = 32'h8000_0100
) (
    input  logic                   clk_i,
    input  logic                   rstN_i,
    input  logic                   instValid_i,
    input  logic                   shouldJump_i,
    input  logic [31:0]            pcJumpDst_i,
    input  logic [31:0]            pc_i,
    input  logic [31:0]            dataAddress_i,
    input  riscvPkg::memInstType_t memInstType_i,
    input  logic                   instInvalid_i,
    input  logic                   priv_i,
    input  logic [31:0]            privCause_i,
    input  logic [31:0]            storeData_i,
    input  logic                   mret_i,
    input  logic                   irqEnable_i,
    input  logic                   hostReq_i,
    input  logic                   hostWe_i,
    input  logic [31:0]            hostAddr_i,
    input  logic [31:0]            hostWdata_i,
    output logic [31:0]            hostRdata_o,
    output logic                   hostGrant_o,
    output logic                   excPresent_o,
    output logic [31:0]            excCause_o,
    output logic [31:0]            trapInfo_o,
    output logic [31:0]            loadData_o,
    output logic [31:0]            mcause_o,
    output logic [31:0]            mepc_o,
    output logic [31:0]            mtval_o,
    output logic                   trapTaken_o,
    output logic [31:0]            trapTarget_o
);

    logic        mtimeExc;
    logic        timerPending;
    logic        excPresent;
    logic [31:0] excCause;
    logic [31:0] trapInfo;

    timerBusIf coreBus ();
    timerBusIf hostBus ();
    timerBusIf slaveBus ();

    // Host master enters through plain ports
    assign hostBus.req   = hostReq_i;
    assign hostBus.we    = hostWe_i;
    assign hostBus.addr  = hostAddr_i;
    assign hostBus.wdata = hostWdata_i;
    assign hostRdata_o   = hostBus.rdata;
    assign hostGrant_o   = hostBus.grant;

    excDetect #(.ramAddrWidth(ramAddrWidth)) excDetect0 (
        .instValid_i   (instValid_i),
        .shouldJump_i  (shouldJump_i),
        .pcJumpDst_i   (pcJumpDst_i),
        .pc_i          (pc_i),
        .dataAddress_i (dataAddress_i),
        .memInstType_i (memInstType_i),
        .instInvalid_i (instInvalid_i),
        .priv_i        (priv_i),
        .privCause_i   (privCause_i),
        .storeData_i   (storeData_i),
        .mtimeExc_i    (mtimeExc),
        .excCause_o    (excCause),
        .trapInfo_o    (trapInfo),
        .excPresent_o  (excPresent),
        .loadData_o    (loadData_o),
        .bus           (coreBus.master)
    );

    trapCsr #(.mtvecAddr(mtvecAddr)) trapCsr0 (
        .clk_i          (clk_i),
        .rstN_i         (rstN_i),
        .trapIn_i       (excPresent),
        .excCause_i     (excCause),
        .trapInfo_i     (trapInfo),
        .pc_i           (pc_i),
        .mret_i         (mret_i),
        .irqEnable_i    (irqEnable_i),
        .timerPending_i (timerPending),
        .mtimeExc_o     (mtimeExc),
        .mcause_o       (mcause_o),
        .mepc_o         (mepc_o),
        .mtval_o        (mtval_o),
        .trapTaken_o    (trapTaken_o),
        .trapTarget_o   (trapTarget_o)
    );

    mtimer mtimer0 (
        .clk_i          (clk_i),
        .rstN_i         (rstN_i),
        .timerPending_o (timerPending),
        .bus            (slaveBus.slave)
    );

    busArbiter busArbiter0 (
        .clk_i  (clk_i),
        .rstN_i (rstN_i),
        .core   (coreBus.arbiter),
        .host   (hostBus.arbiter),
        .slave  (slaveBus.master)
    );

    assign excPresent_o = excPresent;
    assign excCause_o   = excCause;
    assign trapInfo_o   = trapInfo;

endmodule

// File: run.sh
#!/bin/sh
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --assert --timescale 1ns/1ns \
    --top-module trapUnitTb -f build.f -o trapUnitSim || exit 1
simOut=$(./obj_dir/trapUnitSim)
printf '%s\n' "$simOut"
printf '%s\n' "$simOut" | grep -qx "sim passed" && exit 0 || exit 1

// File: sim/trapStimulus.txt
# name kind jump jumpDst pc dataAddr mem ill priv privCause exc cause info data, all hex
# mem 0 none 1 lb 2 lh 3 lw 4 lbu 5 lhu 6 sb 7 sh 8 sw, kinds inst ld hrd hwr hwl race irq mret
allFaults   inst 1 80000102 00001000 00000010 3 1 1 0000000b 1 00000000 80000102 0
pcFault     inst 1 80000100 00001000 80000001 3 1 1 0000000b 1 00000001 00001000 0
illegal     inst 0 00000000 80000040 80000001 3 1 1 0000000b 1 00000002 80000040 0
privEcall   inst 0 00000000 80000044 00000010 8 0 1 0000000b 1 0000000b 80000044 0
privBreak   inst 0 00000000 80000048 80000000 0 0 1 00000003 1 00000003 80000048 0
noJump      inst 0 80000103 8000004c 80000000 0 0 0 00000000 0 00000000 00000000 0
ldAfault    inst 0 00000000 80000050 00000100 3 0 0 00000000 1 00000005 00000100 0
stAfault    inst 0 00000000 80000054 40000000 6 0 0 00000000 1 00000007 40000000 0
ldPastTimer inst 0 00000000 80000058 ffff0010 1 0 0 00000000 1 00000005 ffff0010 0
lbOff3      inst 0 00000000 8000005c 80001003 1 0 0 00000000 0 00000000 00000000 0
lbuOff1     inst 0 00000000 80000060 80001001 4 0 0 00000000 0 00000000 00000000 0
lhOff0      inst 0 00000000 80000064 80001000 2 0 0 00000000 0 00000000 00000000 0
lhOff1      inst 0 00000000 80000068 80001001 2 0 0 00000000 1 00000004 80001001 0
lhuOff2     inst 0 00000000 8000006c 80001002 5 0 0 00000000 0 00000000 00000000 0
lhuOff3     inst 0 00000000 80000070 80001003 5 0 0 00000000 1 00000004 80001003 0
lwOff0      inst 0 00000000 80000074 80001000 3 0 0 00000000 0 00000000 00000000 0
lwOff1      inst 0 00000000 80000078 80001001 3 0 0 00000000 1 00000004 80001001 0
lwOff2      inst 0 00000000 8000007c 80001002 3 0 0 00000000 1 00000004 80001002 0
lwOff3      inst 0 00000000 80000080 80001003 3 0 0 00000000 1 00000004 80001003 0
shOff1      inst 0 00000000 80000084 80001005 7 0 0 00000000 1 00000006 80001005 0
shOff2      inst 0 00000000 80000088 80001006 7 0 0 00000000 0 00000000 00000000 0
sbOff3      inst 0 00000000 8000008c 80001007 6 0 0 00000000 0 00000000 00000000 0
swOff0      inst 0 00000000 80000090 8000100c 8 0 0 00000000 0 00000000 00000000 0
swOff2      inst 0 00000000 80000094 8000100a 8 0 0 00000000 1 00000006 8000100a 0
lwTimerMis  inst 0 00000000 80000098 ffff0002 3 0 0 00000000 1 00000004 ffff0002 0
swTimerMis  inst 0 00000000 8000009c ffff000a 8 0 0 00000000 1 00000006 ffff000a 0
ldCmpReset  ld   0 00000000 800000a0 ffff0008 3 0 0 00000000 0 00000000 00000000 ffffffff
cmpLoReset  hrd  0 00000000 00000000 ffff0008 0 0 0 00000000 0 00000000 00000000 0
cmpLoWrite  hwl  0 00000000 00000000 ffff0008 0 0 0 00000000 0 00000000 00000000 0
cmpLoRead   hrd  0 00000000 00000000 ffff0008 0 0 0 00000000 0 00000000 00000000 0
cmpHiWrite  hwl  0 00000000 00000000 ffff000c 0 0 0 00000000 0 00000000 00000000 0
cmpHiRead   hrd  0 00000000 00000000 ffff000c 0 0 0 00000000 0 00000000 00000000 0
raceMtime   race 0 00000000 800000a4 ffff0000 3 0 0 00000000 0 00000000 00000000 0
cmpHiZero   hwr  0 00000000 00000000 ffff000c 0 0 0 00000000 0 00000000 00000000 0
cmpLoZero   hwr  0 00000000 00000000 ffff0008 0 0 0 00000000 0 00000000 00000000 0
intMasked   inst 0 00000000 800000a8 80000000 0 0 0 00000000 0 00000000 00000000 0
irqOn       irq  0 00000000 00000000 00000000 0 0 0 00000000 0 00000000 00000000 0
timerInt    inst 0 00000000 800000ac 80000000 0 0 0 00000000 1 80000007 00000000 0
intCleared  inst 0 00000000 800000b0 80000000 0 0 0 00000000 0 00000000 00000000 0
mretOn      mret 0 00000000 00000000 00000000 0 0 0 00000000 0 00000000 00000000 0
timerAgain  inst 0 00000000 800000b4 80000000 0 0 0 00000000 1 80000007 00000000 0
intDone     inst 0 00000000 800000b8 80000000 0 0 0 00000000 0 00000000 00000000 0

// File: sim/trapUnitTb.sv
`timescale 1ns/1ns

module trapUnitTb;

    localparam int          ramAddrWidth = 16;
    localparam logic [31:0] mtvecAddr    = 32'h8000_0100;

    typedef struct packed {
        logic        jump;
        logic [31:0] jumpDst;
        logic [31:0] pc;
        logic [31:0] addr;
        logic [3:0]  mem;
        logic        ill;
        logic        priv;
        logic [31:0] privCause;
        logic        exc;
        logic [31:0] cause;
        logic [31:0] info;
        logic [31:0] data;
    } record_t;

    logic                   clk;
    logic                   rstN_i;
    logic                   instValid_i;
    logic                   shouldJump_i;
    logic [31:0]            pcJumpDst_i;
    logic [31:0]            pc_i;
    logic [31:0]            dataAddress_i;
    riscvPkg::memInstType_t memInstType_i;
    logic                   instInvalid_i;
    logic                   priv_i;
    logic [31:0]            privCause_i;
    logic [31:0]            storeData_i;
    logic                   mret_i;
    logic                   irqEnable_i;
    logic                   hostReq_i;
    logic                   hostWe_i;
    logic [31:0]            hostAddr_i;
    logic [31:0]            hostWdata_i;
    logic [31:0]            hostRdata_o;
    logic                   hostGrant_o;
    logic                   excPresent_o;
    logic [31:0]            excCause_o;
    logic [31:0]            trapInfo_o;
    logic [31:0]            loadData_o;
    logic [31:0]            mcause_o;
    logic [31:0]            mepc_o;
    logic [31:0]            mtval_o;
    logic                   trapTaken_o;
    logic [31:0]            trapTarget_o;

    record_t     recs[$];
    string       names[$];
    string       kinds[$];
    logic [31:0] shadow [4];
    logic [31:0] sinceReset;
    logic [7:0]  lfsrState;
    int          checks = 0;
    int          mismatches = 0;
    int          failures = 0;
    int          cycles = 0;
    int          cycleLimit = 0;

    trapUnitTop #(
        .ramAddrWidth (ramAddrWidth),
        .mtvecAddr    (mtvecAddr)
    ) dut0 (
        .clk_i         (clk),
        .rstN_i        (rstN_i),
        .instValid_i   (instValid_i),
        .shouldJump_i  (shouldJump_i),
        .pcJumpDst_i   (pcJumpDst_i),
        .pc_i          (pc_i),
        .dataAddress_i (dataAddress_i),
        .memInstType_i (memInstType_i),
        .instInvalid_i (instInvalid_i),
        .priv_i        (priv_i),
        .privCause_i   (privCause_i),
        .storeData_i   (storeData_i),
        .mret_i        (mret_i),
        .irqEnable_i   (irqEnable_i),
        .hostReq_i     (hostReq_i),
        .hostWe_i      (hostWe_i),
        .hostAddr_i    (hostAddr_i),
        .hostWdata_i   (hostWdata_i),
        .hostRdata_o   (hostRdata_o),
        .hostGrant_o   (hostGrant_o),
        .excPresent_o  (excPresent_o),
        .excCause_o    (excCause_o),
        .trapInfo_o    (trapInfo_o),
        .loadData_o    (loadData_o),
        .mcause_o      (mcause_o),
        .mepc_o        (mepc_o),
        .mtval_o       (mtval_o),
        .trapTaken_o   (trapTaken_o),
        .trapTarget_o  (trapTarget_o)
    );

    always #20 clk = ~clk;

    // Edges seen since reset, the value mtime should hold
    always @(posedge clk) begin
        if (!rstN_i) begin
            sinceReset <= '0;
        end else begin
            sinceReset <= sinceReset + 32'd1;
        end
    end

    always @(posedge clk) begin
        cycles <= cycles + 1;
        if (cycleLimit > 0 && cycles >= cycleLimit) begin
            failures++;
            $display("Timeout, the run did not end within %0d cycles", cycleLimit);
            $display("checks %0d, mismatches %0d, other errors %0d",
                     checks, mismatches, failures);
            $display("sim failed");
            $finish;
        end
    end

    // x^8 + x^6 + x^5 + x^4 + 1
    function automatic logic [7:0] lfsrNext(input logic [7:0] s);
        return {s[6:0], s[7] ^ s[5] ^ s[4] ^ s[3]};
    endfunction

    task automatic drawRandomWord(output logic [31:0] w);
        w = '0;
        for (int i = 0; i < 32; i++) begin
            lfsrState = lfsrNext(lfsrState);
            w = {w[30:0], lfsrState[0]};
        end
    endtask

    task automatic checkValue(input string name, input string what,
                              input logic [31:0] exp, input logic [31:0] act);
        checks++;
        assert (act === exp) else begin
            mismatches++;
            $display("Mismatch %s %s expected %h actual %h", name, what, exp, act);
        end
    endtask

    task automatic checkFlag(input string name, input string what,
                             input logic exp, input logic act);
        checks++;
        assert (act === exp) else begin
            mismatches++;
            $display("Mismatch %s %s expected %b actual %b", name, what, exp, act);
        end
    endtask

    task automatic loadRecords();
        int                fd;
        int                code;
        logic [8*32-1:0]   tok;
        logic [8*32-1:0]   kindTok;
        logic [8*256-1:0]  rest;
        logic [31:0]       jump, jumpDst, pc, addr, mem, ill;
        logic [31:0]       priv, privCause, exc, cause, info, data;
        record_t           r;
        fd = $fopen("sim/trapStimulus.txt", "r");
        if (fd == 0) begin
            failures++;
            $display("Could not open sim/trapStimulus.txt");
        end else begin
            while (!$feof(fd)) begin
                code = $fscanf(fd, "%s", tok);
                if (code == 1) begin
                    if (string'(tok) == "#") begin
                        code = $fgets(rest, fd);
                    end else begin
                        code = $fscanf(fd, "%s %h %h %h %h %h %h %h %h %h %h %h %h",
                                       kindTok, jump, jumpDst, pc, addr, mem, ill,
                                       priv, privCause, exc, cause, info, data);
                        if (code != 13) begin
                            failures++;
                            $display("Stimulus record %s is incomplete", string'(tok));
                        end else begin
                            r.jump      = jump[0];
                            r.jumpDst   = jumpDst;
                            r.pc        = pc;
                            r.addr      = addr;
                            r.mem       = mem[3:0];
                            r.ill       = ill[0];
                            r.priv      = priv[0];
                            r.privCause = privCause;
                            r.exc       = exc[0];
                            r.cause     = cause;
                            r.info      = info;
                            r.data      = data;
                            recs.push_back(r);
                            names.push_back(string'(tok));
                            kinds.push_back(string'(kindTok));
                        end
                    end
                end
            end
            $fclose(fd);
        end
    endtask

    task automatic driveInst(input record_t r);
        instValid_i   <= 1'b1;
        shouldJump_i  <= r.jump;
        pcJumpDst_i   <= r.jumpDst;
        pc_i          <= r.pc;
        dataAddress_i <= r.addr;
        memInstType_i <= riscvPkg::memInstType_t'(r.mem);
        instInvalid_i <= r.ill;
        priv_i        <= r.priv;
        privCause_i   <= r.privCause;
        storeData_i   <= '0;
    endtask

    task automatic driveIdle();
        instValid_i   <= 1'b0;
        shouldJump_i  <= 1'b0;
        pcJumpDst_i   <= '0;
        pc_i          <= '0;
        dataAddress_i <= '0;
        memInstType_i <= riscvPkg::MEM_NONE;
        instInvalid_i <= 1'b0;
        priv_i        <= 1'b0;
        privCause_i   <= '0;
        storeData_i   <= '0;
    endtask

    // Classification in the issue cycle, trap capture one cycle later
    task automatic runInst(input string name, input record_t r, input logic checkLoad);
        @(posedge clk);
        driveInst(r);
        @(negedge clk);
        checkFlag(name, "excPresent", r.exc, excPresent_o);
        if (r.exc) begin
            checkValue(name, "excCause", r.cause, excCause_o);
        end
        checkValue(name, "trapInfo", r.info, trapInfo_o);
        if (checkLoad) begin
            checkValue(name, "loadData", r.data, loadData_o);
        end
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        checkFlag(name, "trapTaken", r.exc, trapTaken_o);
        if (r.exc) begin
            checkValue(name, "trapTarget", mtvecAddr, trapTarget_o);
            checkValue(name, "mcause", r.cause, mcause_o);
            checkValue(name, "mepc", r.pc, mepc_o);
            checkValue(name, "mtval", r.info, mtval_o);
        end
    endtask

    task automatic hostWrite(input string name, input logic [31:0] addr,
                             input logic [31:0] data);
        @(posedge clk);
        hostReq_i   <= 1'b1;
        hostWe_i    <= 1'b1;
        hostAddr_i  <= addr;
        hostWdata_i <= data;
        @(negedge clk);
        checkFlag(name, "hostGrant", 1'b1, hostGrant_o);
        @(posedge clk);
        hostReq_i <= 1'b0;
        hostWe_i  <= 1'b0;
        shadow[addr[3:2]] = data;
    endtask

    task automatic hostRead(input string name, input logic [31:0] addr);
        @(posedge clk);
        hostReq_i  <= 1'b1;
        hostWe_i   <= 1'b0;
        hostAddr_i <= addr;
        @(negedge clk);
        checkFlag(name, "hostGrant", 1'b1, hostGrant_o);
        checkValue(name, "hostRdata", shadow[addr[3:2]], hostRdata_o);
        @(posedge clk);
        hostReq_i <= 1'b0;
    endtask

    // Core timer load and host read collide, host waits one cycle
    task automatic raceLoad(input string name, input record_t r);
        @(posedge clk);
        driveInst(r);
        hostReq_i  <= 1'b1;
        hostWe_i   <= 1'b0;
        hostAddr_i <= memMapPkg::MTIMECMP_LO;
        @(negedge clk);
        checkFlag(name, "excPresent", 1'b0, excPresent_o);
        checkValue(name, "loadData", sinceReset, loadData_o);
        checkFlag(name, "hostGrant", 1'b0, hostGrant_o);
        @(posedge clk);
        driveIdle();
        @(negedge clk);
        checkFlag(name, "hostGrant", 1'b1, hostGrant_o);
        checkValue(name, "hostRdata", shadow[2], hostRdata_o);
        @(posedge clk);
        hostReq_i <= 1'b0;
    endtask

    task automatic pulseIrqEnable();
        @(posedge clk);
        irqEnable_i <= 1'b1;
        @(posedge clk);
        irqEnable_i <= 1'b0;
    endtask

    task automatic pulseMret();
        @(posedge clk);
        mret_i <= 1'b1;
        @(posedge clk);
        mret_i <= 1'b0;
    endtask

    initial begin
        logic [31:0] randWord;
        clk         = 1'b0;
        lfsrState   = 8'd58;
        shadow[0]   = '0;
        shadow[1]   = '0;
        shadow[2]   = '1;
        shadow[3]   = '1;
        rstN_i      <= 1'b0;
        mret_i      <= 1'b0;
        irqEnable_i <= 1'b0;
        hostReq_i   <= 1'b0;
        hostWe_i    <= 1'b0;
        hostAddr_i  <= '0;
        hostWdata_i <= '0;
        driveIdle();
        loadRecords();
        if (recs.size() == 0) begin
            failures++;
            $display("No stimulus records were read");
        end
        cycleLimit = recs.size() * 4 + 20;

        repeat (2) @(posedge clk);
        rstN_i <= 1'b1;
        @(negedge clk);
        checkFlag("reset", "trapTaken", 1'b0, trapTaken_o);
        checkFlag("reset", "hostGrant", 1'b0, hostGrant_o);

        for (int i = 0; i < recs.size(); i++) begin
            if (kinds[i] == "inst" || kinds[i] == "ld") begin
                runInst(names[i], recs[i], kinds[i] == "ld");
            end else if (kinds[i] == "hwr") begin
                hostWrite(names[i], recs[i].addr, recs[i].data);
            end else if (kinds[i] == "hwl") begin
                drawRandomWord(randWord);
                hostWrite(names[i], recs[i].addr, randWord);
            end else if (kinds[i] == "hrd") begin
                hostRead(names[i], recs[i].addr);
            end else if (kinds[i] == "race") begin
                raceLoad(names[i], recs[i]);
            end else if (kinds[i] == "irq") begin
                pulseIrqEnable();
            end else if (kinds[i] == "mret") begin
                pulseMret();
            end else begin
                failures++;
                $display("Record %s has an unknown kind %s", names[i], kinds[i]);
            end
        end

        @(posedge clk);
        $display("checks %0d, mismatches %0d, other errors %0d", checks, mismatches, failures);
        if (mismatches == 0 && failures == 0) begin
            $display("sim passed");
        end else begin
            $display("sim failed");
        end
        $finish;
    end

endmodule
